// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_controller.sv
  - hdl/dcache_datapath.sv
  - hdl/dcache_line_xfer.sv
  - hdl/dcache_top.sv
  - target: test
    files:
      - dv/dcache_mem_model.sv
      - dv/dcache_chk.sv
      - dv/dcache_tb.sv

// ==== dv/dcache_chk.sv ====
module dcache_chk (
    input logic                          clk_i,
    input logic                          rst_ni,
    input logic                          req_i,
    input logic                          flush_i,
    input logic                          ack_i,
    input logic                          wb_cyc_i,
    input logic                          wb_stb_i,
    input logic                          wb_we_i,
    input logic [dcache_pkg::ADDR_W-1:0] wb_adr_i,
    input logic                          wb_ack_i,
    input dcache_pkg::dcache_state_e     state_i
);

    // Count of failed assertions
    int unsigned fail_count = 0;

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_i |-> wb_cyc_i)
        else begin
            $error("wb_stb_o high without wb_cyc_o");
            fail_count++;
        end

    // Classic cycle holds address and direction until the slave acks
    stb_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i) && $stable(wb_we_i))
        else begin
            $error("wishbone cycle changed before wb_ack_i");
            fail_count++;
        end

    ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |=> !ack_i)
        else begin
            $error("ack_o high two cycles in a row");
            fail_count++;
        end

    ack_has_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(ack_i) |-> req_i || flush_i)
        else begin
            $error("ack_o rose without req_i or flush_i");
            fail_count++;
        end

    // Bus cycles only while the controller waits for a line transfer
    cyc_in_mem_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_cyc_i |-> state_i inside {dcache_pkg::DCACHE_WRITE_BACK,
                                     dcache_pkg::DCACHE_ALLOCATE})
        else begin
            $error("wb_cyc_o outside write-back or allocate");
            fail_count++;
        end

endmodule

bind dcache_top dcache_chk dcache_chk_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .flush_i  (flush_i),
    .ack_i    (ack_o),
    .wb_cyc_i (wb_cyc_o),
    .wb_stb_i (wb_stb_o),
    .wb_we_i  (wb_we_o),
    .wb_adr_i (wb_adr_o),
    .wb_ack_i (wb_ack_i),
    .state_i  (dcache_controller_i.state_q)
);

// ==== dv/dcache_mem_model.sv ====
module dcache_mem_model #(
    parameter int unsigned MEM_WORDS = 1024,
    parameter logic [31:0] FILL_BASE = 32'h5a00_0000
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    localparam int unsigned IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic [1:0]       wait_q;
    logic [IDX_W-1:0] word_idx;
    integer           seed;

    assign word_idx = wb_adr_i[IDX_W+1:2];

    // Every word starts as its own word address plus the fill constant
    initial begin
        seed = 32'he854_92e4;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i + FILL_BASE;
        end
    end

    // Registered ack after 0 to 3 extra wait cycles
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            wb_ack_o <= 1'b0;
            wait_q   <= '0;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;
            wait_q   <= 2'($unsigned($random(seed)) % 4);
        end else if (wb_cyc_i && wb_stb_i) begin
            if (wait_q != 0) begin
                wait_q <= wait_q - 1'b1;
            end else begin
                wb_ack_o <= 1'b1;
                wb_dat_o <= mem[word_idx];
                if (wb_we_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel_i[b]) begin
                            mem[word_idx][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== dv/dcache_tb.sv ====
module dcache_tb;

    localparam int unsigned NUM_SETS  = 8;
    localparam int unsigned MEM_WORDS = 1024;
    localparam logic [31:0] FILL_BASE = 32'h5a00_0000;
    localparam int unsigned NUM_TESTS = 14;

    localparam int OP_READ  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_FLUSH = 2;
    localparam int OP_DESEL = 3;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        req;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        dmem_sel;
    logic        flush;
    logic [31:0] rdata;
    logic        ack;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_wdat;
    logic [31:0] wb_rdat;
    logic [3:0]  wb_sel;
    logic        wb_ack;

    // Stimulus table, one column per array
    string       t_name  [NUM_TESTS];
    int          t_op    [NUM_TESTS];
    logic [31:0] t_addr  [NUM_TESTS];
    logic [31:0] t_wdata [NUM_TESTS];
    logic [3:0]  t_be    [NUM_TESTS];
    int          t_rd    [NUM_TESTS];
    int          t_wr    [NUM_TESTS];
    bit          t_hit   [NUM_TESTS];

    logic [31:0] shadow [MEM_WORDS];

    // Completed Wishbone beats of the current entry
    logic [31:0] beat_adr [$];
    logic [31:0] beat_dat [$];
    logic [3:0]  beat_sel [$];
    bit          beat_we  [$];

    always #5 clk_i = ~clk_i;

    dcache_top #(
        .NUM_SETS (NUM_SETS)
    ) dcache_top_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req_i      (req),
        .wr_i       (wr),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .be_i       (be),
        .dmem_sel_i (dmem_sel),
        .flush_i    (flush),
        .rdata_o    (rdata),
        .ack_o      (ack),
        .wb_cyc_o   (wb_cyc),
        .wb_stb_o   (wb_stb),
        .wb_we_o    (wb_we),
        .wb_adr_o   (wb_adr),
        .wb_dat_o   (wb_wdat),
        .wb_sel_o   (wb_sel),
        .wb_dat_i   (wb_rdat),
        .wb_ack_i   (wb_ack)
    );

    dcache_mem_model #(
        .MEM_WORDS (MEM_WORDS),
        .FILL_BASE (FILL_BASE)
    ) dcache_mem_model_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdat),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack)
    );

    always @(negedge clk_i) begin
        if (wb_cyc && wb_stb && wb_ack) begin
            beat_adr.push_back(wb_adr);
            beat_we.push_back(wb_we);
            beat_sel.push_back(wb_sel);
            beat_dat.push_back(wb_we ? wb_wdat : wb_rdat);
        end
    end

    // Stop as soon as a bound assertion has fired
    always @(negedge clk_i) begin
        if (dcache_top_i.dcache_chk_i.fail_count != 0) begin
            $display("an assertion on the bus or the core handshake failed");
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input int i, input string name, input int op,
                             input logic [31:0] a, input logic [31:0] d, input logic [3:0] b,
                             input int n_rd, input int n_wr, input bit hit);
        t_name[i]  = name;
        t_op[i]    = op;
        t_addr[i]  = a;
        t_wdata[i] = d;
        t_be[i]    = b;
        t_rd[i]    = n_rd;
        t_wr[i]    = n_wr;
        t_hit[i]   = hit;
    endtask

    task automatic run_entry(input int i);
        int cycles;
        int n_rd;
        int n_wr;
        beat_adr.delete();
        beat_dat.delete();
        beat_sel.delete();
        beat_we.delete();
        req      = (t_op[i] != OP_FLUSH);
        wr       = (t_op[i] == OP_WRITE);
        flush    = (t_op[i] == OP_FLUSH);
        dmem_sel = (t_op[i] != OP_DESEL);
        addr     = t_addr[i];
        wdata    = t_wdata[i];
        be       = t_be[i];
        cycles   = 0;
        n_rd     = 0;
        n_wr     = 0;
        if (t_op[i] == OP_DESEL) begin
            // Killed request must stay silent on both sides
            repeat (20) begin
                @(negedge clk_i);
                check_value({t_name[i], " ack_o"}, 0, ack);
                check_value({t_name[i], " wb_cyc_o"}, 0, wb_cyc);
            end
        end else begin
            do begin
                @(negedge clk_i);
                cycles++;
            end while (!ack);
            if (t_hit[i]) begin
                check_value({t_name[i], " ack latency"}, 1, cycles - 1);
            end
            // Bus data must match memory contents before this entry's write
            foreach (beat_adr[k]) begin
                check_value({t_name[i], " beat data"}, shadow[beat_adr[k][11:2]], beat_dat[k]);
                check_value({t_name[i], " wb_sel_o"}, 4'hf, beat_sel[k]);
                if (beat_we[k]) begin
                    check_value({t_name[i], " write beat offset"}, n_wr % 4, beat_adr[k][3:2]);
                    n_wr++;
                end else begin
                    check_value({t_name[i], " read beat address"},
                                {t_addr[i][31:4], 2'(n_rd), 2'b00}, beat_adr[k]);
                    n_rd++;
                end
            end
            check_value({t_name[i], " read beats"}, t_rd[i], n_rd);
            check_value({t_name[i], " write beats"}, t_wr[i], n_wr);
            if (t_op[i] == OP_WRITE) begin
                for (int b = 0; b < 4; b++) begin
                    if (t_be[i][b]) begin
                        shadow[t_addr[i][11:2]][b*8 +: 8] = t_wdata[i][b*8 +: 8];
                    end
                end
            end else if (t_op[i] == OP_READ) begin
                check_value(t_name[i], shadow[t_addr[i][11:2]], rdata);
            end else begin
                for (int w = 0; w < MEM_WORDS; w++) begin
                    check_value($sformatf("%s mem[%0d]", t_name[i], w), shadow[w],
                                dcache_mem_model_i.mem[w]);
                end
            end
        end
        @(posedge clk_i);
        #1;
        req      = 1'b0;
        wr       = 1'b0;
        flush    = 1'b0;
        dmem_sel = 1'b1;
    endtask

    initial begin
        repeat (NUM_TESTS * 200 + 8) @(posedge clk_i);
        $display("timeout: the cache did not answer a request in time");
        $display("TB FAILED");
        $fatal(1);
    end

    initial begin
        rst_ni   = 1'b0;
        req      = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        wdata    = '0;
        be       = '0;
        dmem_sel = 1'b1;
        flush    = 1'b0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            shadow[w] = w + FILL_BASE;
        end

        // Sets are addr[6:4], so 0x100, 0x180 and 0x300 share set 0
        add_entry(0,  "cold_read_miss",   OP_READ,  32'h100, '0, 4'hf, 4, 0, 1'b0);
        add_entry(1,  "read_hit",         OP_READ,  32'h108, '0, 4'hf, 0, 0, 1'b1);
        add_entry(2,  "partial_write",    OP_WRITE, 32'h104, 32'ha5a5_1234, 4'b0101, 0, 0, 1'b1);
        add_entry(3,  "read_merged",      OP_READ,  32'h104, '0, 4'hf, 0, 0, 1'b1);
        add_entry(4,  "evict_dirty",      OP_READ,  32'h180, '0, 4'hf, 4, 4, 1'b0);
        add_entry(5,  "reread_first",     OP_READ,  32'h104, '0, 4'hf, 4, 0, 1'b0);
        add_entry(6,  "write_miss",       OP_WRITE, 32'h2c8, 32'hdead_beef, 4'hf, 4, 0, 1'b0);
        add_entry(7,  "write_set7",       OP_WRITE, 32'h0f0, 32'h7700_0000, 4'b1000, 4, 0, 1'b0);
        add_entry(8,  "write_hit_set0",   OP_WRITE, 32'h10c, 32'h0000_beef, 4'b0011, 0, 0, 1'b1);
        add_entry(9,  "flush_dirty",      OP_FLUSH, '0, '0, 4'h0, 0, 12, 1'b0);
        add_entry(10, "read_after_flush", OP_READ,  32'h2c8, '0, 4'hf, 0, 0, 1'b1);
        add_entry(11, "deselected_read",  OP_DESEL, 32'h300, '0, 4'hf, 0, 0, 1'b0);
        add_entry(12, "read_after_desel", OP_READ,  32'h300, '0, 4'hf, 4, 0, 1'b0);
        add_entry(13, "flush_clean",      OP_FLUSH, '0, '0, 4'h0, 0, 0, 1'b0);

        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end

        if (dcache_top_i.dcache_chk_i.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("assertion checks failed %0d times", dcache_top_i.dcache_chk_i.fail_count);
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== hdl/dcache_controller.sv ====
module dcache_controller #(
    parameter int unsigned NUM_SETS = 8
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,

    // Datapath status
    input  logic                         cache_hit_i,
    input  logic                         cache_evict_req_i,

    // Core side
    input  logic                         flush_i,
    input  logic                         req_i,
    input  logic                         wr_i,
    input  logic                         dmem_sel_i,
    output logic                         ack_o,

    // Datapath control
    output logic                         cache_wr_o,
    output logic                         cache_line_wr_o,
    output logic                         cache_line_clean_o,
    output logic                         cache_wrb_req_o,
    output logic [$clog2(NUM_SETS)-1:0]  evict_index_o,

    // Line transfer unit
    input  logic                         mem_ack_i,
    output logic                         mem_req_o,
    output logic                         mem_wr_o
);

    localparam int unsigned IDX_W = $clog2(NUM_SETS);
    localparam logic [IDX_W-1:0] LAST_SET = IDX_W'(NUM_SETS - 1);

    dcache_pkg::dcache_state_e state_q, state_d;
    logic [IDX_W-1:0] evict_index_q, evict_index_d;

    logic hit;
    logic miss;
    logic kill;

    // A request only counts when it addresses cacheable memory
    assign hit  = req_i & dmem_sel_i & cache_hit_i;
    assign miss = req_i & dmem_sel_i & ~cache_hit_i;

    // Flush walks the sets on its own, so the select only kills requests
    assign kill = ~dmem_sel_i & ~flush_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= dcache_pkg::DCACHE_IDLE;
            evict_index_q <= '0;
        end else begin
            state_q       <= state_d;
            evict_index_q <= evict_index_d;
        end
    end

    always_comb begin
        state_d            = state_q;
        evict_index_d      = evict_index_q;
        ack_o              = 1'b0;
        cache_wr_o         = 1'b0;
        cache_line_wr_o    = 1'b0;
        cache_line_clean_o = 1'b0;
        cache_wrb_req_o    = 1'b0;
        mem_req_o          = 1'b0;
        mem_wr_o           = 1'b0;

        unique case (state_q)
            dcache_pkg::DCACHE_IDLE: begin
                if (flush_i) begin
                    state_d       = dcache_pkg::DCACHE_FLUSH;
                    evict_index_d = '0;
                end else if (hit) begin
                    // Word write happens now, the ack follows next cycle
                    if (wr_i) begin
                        state_d    = dcache_pkg::DCACHE_WRITE;
                        cache_wr_o = 1'b1;
                    end else begin
                        state_d = dcache_pkg::DCACHE_READ;
                    end
                end else if (miss) begin
                    if (cache_evict_req_i) begin
                        state_d = dcache_pkg::DCACHE_WRITE_BACK;
                    end else begin
                        state_d = dcache_pkg::DCACHE_ALLOCATE;
                    end
                end
            end

            dcache_pkg::DCACHE_READ,
            dcache_pkg::DCACHE_WRITE: begin
                ack_o   = 1'b1;
                state_d = dcache_pkg::DCACHE_IDLE;
            end

            dcache_pkg::DCACHE_WRITE_BACK: begin
                if (mem_ack_i) begin
                    if (flush_i) begin
                        // Stay on this set, it reads clean next cycle
                        state_d            = dcache_pkg::DCACHE_FLUSH;
                        cache_line_clean_o = 1'b1;
                    end else begin
                        state_d = dcache_pkg::DCACHE_ALLOCATE;
                    end
                end else begin
                    mem_req_o       = 1'b1;
                    mem_wr_o        = 1'b1;
                    cache_wrb_req_o = 1'b1;
                end
            end

            dcache_pkg::DCACHE_ALLOCATE: begin
                // Fill line is complete once the transfer acknowledges
                if (mem_ack_i) begin
                    state_d         = dcache_pkg::DCACHE_IDLE;
                    cache_line_wr_o = 1'b1;
                end else begin
                    mem_req_o = 1'b1;
                end
            end

            dcache_pkg::DCACHE_FLUSH: begin
                if (cache_evict_req_i) begin
                    state_d = dcache_pkg::DCACHE_WRITE_BACK;
                end else if (evict_index_q == LAST_SET) begin
                    ack_o         = 1'b1;
                    state_d       = dcache_pkg::DCACHE_IDLE;
                    evict_index_d = '0;
                end else begin
                    evict_index_d = evict_index_q + 1'b1;
                end
            end

            default: begin
                state_d = dcache_pkg::DCACHE_IDLE;
            end
        endcase

        // Request not meant for the cache
        if (kill) begin
            state_d         = dcache_pkg::DCACHE_IDLE;
            evict_index_d   = '0;
            ack_o           = 1'b0;
            cache_wr_o      = 1'b0;
            cache_line_wr_o = 1'b0;
            cache_wrb_req_o = 1'b0;
            mem_req_o       = 1'b0;
            mem_wr_o        = 1'b0;
        end
    end

    assign evict_index_o = evict_index_q;

endmodule

// ==== hdl/dcache_datapath.sv ====
module dcache_datapath #(
    parameter int unsigned NUM_SETS = 8
) (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,

    // Core request
    input  logic [dcache_pkg::ADDR_W-1:0]                   addr_i,
    input  logic [dcache_pkg::WORD_W-1:0]                   wdata_i,
    input  logic [dcache_pkg::WORD_W/8-1:0]                 be_i,
    output logic [dcache_pkg::WORD_W-1:0]                   rdata_o,

    // Controller side
    input  logic                                            cache_wr_i,
    input  logic                                            cache_line_wr_i,
    input  logic                                            cache_line_clean_i,
    input  logic                                            cache_wrb_req_i,
    input  logic [$clog2(NUM_SETS)-1:0]                     evict_index_i,
    input  logic                                            flush_i,
    output logic                                            cache_hit_o,
    output logic                                            cache_evict_req_o,

    // Line transfer side
    input  logic [dcache_pkg::LINE_W-1:0]                   fill_line_i,
    output logic [dcache_pkg::LINE_W-1:0]                   victim_line_o,
    output logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] mem_line_adr_o
);

    localparam int unsigned IDX_W      = $clog2(NUM_SETS);
    localparam int unsigned TAG_W      = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - IDX_W;
    localparam int unsigned NUM_BYTES  = dcache_pkg::WORD_W / 8;
    localparam int unsigned BYTE_W     = $clog2(NUM_BYTES);
    localparam int unsigned WORD_SEL_W = $clog2(dcache_pkg::WORDS_PER_LINE);

    // Per-set storage
    logic [NUM_SETS-1:0]           valid_q;
    logic [NUM_SETS-1:0]           dirty_q;
    logic [TAG_W-1:0]              tag_q  [NUM_SETS];
    logic [dcache_pkg::LINE_W-1:0] data_q [NUM_SETS];

    logic [IDX_W-1:0]      req_index;
    logic [IDX_W-1:0]      sel_index;
    logic [TAG_W-1:0]      req_tag;
    logic [WORD_SEL_W-1:0] word_sel;

    assign req_index = addr_i[dcache_pkg::OFFSET_W +: IDX_W];
    assign req_tag   = addr_i[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign word_sel  = addr_i[BYTE_W +: WORD_SEL_W];

    // The flush walk takes over the victim set
    assign sel_index = flush_i ? evict_index_i : req_index;

    assign cache_hit_o       = valid_q[req_index] & (tag_q[req_index] == req_tag);
    assign cache_evict_req_o = valid_q[sel_index] & dirty_q[sel_index];

    assign rdata_o       = data_q[req_index][word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    assign victim_line_o = data_q[sel_index];

    // Victim address during write-back, else the line being requested
    assign mem_line_adr_o = cache_wrb_req_i ? {tag_q[sel_index], sel_index}
                                            : addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (cache_line_wr_i) begin
                valid_q[req_index] <= 1'b1;
                dirty_q[req_index] <= 1'b0;
            end
            if (cache_wr_i) begin
                dirty_q[req_index] <= 1'b1;
            end
            if (cache_line_clean_i) begin
                dirty_q[sel_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cache_line_wr_i) begin
            data_q[req_index] <= fill_line_i;
            tag_q[req_index]  <= req_tag;
        end
        // Byte merge into the addressed word
        if (cache_wr_i) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (be_i[b]) begin
                    data_q[req_index][word_sel*dcache_pkg::WORD_W + b*8 +: 8] <=
                        wdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/dcache_line_xfer.sv ====
module dcache_line_xfer (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,

    // Controller handshake
    input  logic                                            mem_req_i,
    input  logic                                            mem_wr_i,
    output logic                                            mem_ack_o,

    // Line data and address
    input  logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] line_adr_i,
    input  logic [dcache_pkg::LINE_W-1:0]                   wr_line_i,
    output logic [dcache_pkg::LINE_W-1:0]                   rd_line_o,

    // Wishbone classic master
    output logic                                            wb_cyc_o,
    output logic                                            wb_stb_o,
    output logic                                            wb_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]                   wb_adr_o,
    output logic [dcache_pkg::WORD_W-1:0]                   wb_dat_o,
    output logic [dcache_pkg::WORD_W/8-1:0]                 wb_sel_o,
    input  logic [dcache_pkg::WORD_W-1:0]                   wb_dat_i,
    input  logic                                            wb_ack_i
);

    localparam int unsigned BEAT_W = $clog2(dcache_pkg::WORDS_PER_LINE);
    localparam int unsigned BYTE_W = $clog2(dcache_pkg::WORD_W / 8);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(dcache_pkg::WORDS_PER_LINE - 1);

    typedef enum logic [1:0] {
        XFER_IDLE,
        XFER_BUSY,
        XFER_DONE,
        XFER_HOLD
    } xfer_state_e;

    xfer_state_e state_q, state_d;
    logic [BEAT_W-1:0] beat_q;
    logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] adr_q;
    logic we_q;
    logic [dcache_pkg::LINE_W-1:0] rd_line_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            XFER_IDLE: if (mem_req_i) state_d = XFER_BUSY;
            XFER_BUSY: if (wb_ack_i && beat_q == LAST_BEAT) state_d = XFER_DONE;
            // Wait for the controller to let go before the next line
            XFER_DONE: state_d = mem_req_i ? XFER_HOLD : XFER_IDLE;
            XFER_HOLD: if (!mem_req_i) state_d = XFER_IDLE;
            default:   state_d = XFER_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= XFER_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == XFER_IDLE) begin
                beat_q <= '0;
            end else if (state_q == XFER_BUSY && wb_ack_i) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // Line address and direction are captured when a transfer starts
    always_ff @(posedge clk_i) begin
        if (state_q == XFER_IDLE && mem_req_i) begin
            adr_q <= line_adr_i;
            we_q  <= mem_wr_i;
        end
        if (state_q == XFER_BUSY && wb_ack_i) begin
            rd_line_q[beat_q*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] <= wb_dat_i;
        end
    end

    assign wb_cyc_o  = (state_q == XFER_BUSY);
    assign wb_stb_o  = (state_q == XFER_BUSY);
    assign wb_we_o   = (state_q == XFER_BUSY) & we_q;
    assign wb_adr_o  = {adr_q, beat_q, {BYTE_W{1'b0}}};
    assign wb_dat_o  = wr_line_i[beat_q*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    assign wb_sel_o  = '1;

    assign mem_ack_o = (state_q == XFER_DONE);
    assign rd_line_o = rd_line_q;

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    // Word and bus width, shared with the Wishbone side
    localparam int unsigned WORD_W = 32;

    // Byte address width
    localparam int unsigned ADDR_W = 32;

    // Line geometry
    localparam int unsigned WORDS_PER_LINE = 4;
    localparam int unsigned LINE_W = WORDS_PER_LINE * WORD_W;

    // Byte offset bits inside one line
    localparam int unsigned OFFSET_W = $clog2(LINE_W / 8);

    // Controller states
    typedef enum logic [2:0] {
        DCACHE_IDLE       = 3'd0,
        DCACHE_READ       = 3'd1,
        DCACHE_WRITE      = 3'd2,
        DCACHE_ALLOCATE   = 3'd3,
        DCACHE_WRITE_BACK = 3'd4,
        DCACHE_FLUSH      = 3'd5
    } dcache_state_e;

endpackage

// ==== hdl/dcache_top.sv ====
module dcache_top #(
    parameter int unsigned NUM_SETS = 8
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    // Core side
    input  logic                              req_i,
    input  logic                              wr_i,
    input  logic [dcache_pkg::ADDR_W-1:0]     addr_i,
    input  logic [dcache_pkg::WORD_W-1:0]     wdata_i,
    input  logic [dcache_pkg::WORD_W/8-1:0]   be_i,
    input  logic                              dmem_sel_i,
    input  logic                              flush_i,
    output logic [dcache_pkg::WORD_W-1:0]     rdata_o,
    output logic                              ack_o,

    // Wishbone classic master
    output logic                              wb_cyc_o,
    output logic                              wb_stb_o,
    output logic                              wb_we_o,
    output logic [dcache_pkg::ADDR_W-1:0]     wb_adr_o,
    output logic [dcache_pkg::WORD_W-1:0]     wb_dat_o,
    output logic [dcache_pkg::WORD_W/8-1:0]   wb_sel_o,
    input  logic [dcache_pkg::WORD_W-1:0]     wb_dat_i,
    input  logic                              wb_ack_i
);

    logic cache_hit;
    logic cache_evict_req;
    logic cache_wr;
    logic cache_line_wr;
    logic cache_line_clean;
    logic cache_wrb_req;
    logic [$clog2(NUM_SETS)-1:0] evict_index;

    logic mem_req;
    logic mem_wr;
    logic mem_ack;
    logic [dcache_pkg::LINE_W-1:0] victim_line;
    logic [dcache_pkg::LINE_W-1:0] fill_line;
    logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0] mem_line_adr;

    dcache_controller #(
        .NUM_SETS (NUM_SETS)
    ) dcache_controller_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .cache_hit_i        (cache_hit),
        .cache_evict_req_i  (cache_evict_req),
        .flush_i            (flush_i),
        .req_i              (req_i),
        .wr_i               (wr_i),
        .dmem_sel_i         (dmem_sel_i),
        .ack_o              (ack_o),
        .cache_wr_o         (cache_wr),
        .cache_line_wr_o    (cache_line_wr),
        .cache_line_clean_o (cache_line_clean),
        .cache_wrb_req_o    (cache_wrb_req),
        .evict_index_o      (evict_index),
        .mem_ack_i          (mem_ack),
        .mem_req_o          (mem_req),
        .mem_wr_o           (mem_wr)
    );

    dcache_datapath #(
        .NUM_SETS (NUM_SETS)
    ) dcache_datapath_i (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .addr_i             (addr_i),
        .wdata_i            (wdata_i),
        .be_i               (be_i),
        .rdata_o            (rdata_o),
        .cache_wr_i         (cache_wr),
        .cache_line_wr_i    (cache_line_wr),
        .cache_line_clean_i (cache_line_clean),
        .cache_wrb_req_i    (cache_wrb_req),
        .evict_index_i      (evict_index),
        .flush_i            (flush_i),
        .cache_hit_o        (cache_hit),
        .cache_evict_req_o  (cache_evict_req),
        .fill_line_i        (fill_line),
        .victim_line_o      (victim_line),
        .mem_line_adr_o     (mem_line_adr)
    );

    dcache_line_xfer dcache_line_xfer_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .mem_req_i  (mem_req),
        .mem_wr_i   (mem_wr),
        .mem_ack_o  (mem_ack),
        .line_adr_i (mem_line_adr),
        .wr_line_i  (victim_line),
        .rd_line_o  (fill_line),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .wb_sel_o   (wb_sel_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i)
    );

endmodule

// ==== list.f ====
hdl/dcache_pkg.sv
hdl/dcache_controller.sv
hdl/dcache_datapath.sv
hdl/dcache_line_xfer.sv
hdl/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_chk.sv
dv/dcache_tb.sv
